/* vlog.f */
+incdir+src
src/i2c_bus_pkg.sv
src/reg_map_pkg.sv
src/i2c_line_sampler.sv
src/i2c_slave_ctrl.sv
src/i2c_reg_file.sv
src/i2c_slave_top.sv
testbench/tb_i2c_slave.sv

/* Makefile */
TOP = tb_i2c_slave

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* testbench/tb_i2c_slave.sv */
`timescale 1ns/1ps
`include "i2c_macros.svh"

module tb_i2c_slave;

	localparam int HALF_BIT   = 32;     // sys_clk cycles per SCL phase
	localparam int NUM_RANDOM = 16;
	// about 330 bytes of 9 bits at 64 cycles each with margin on top
	localparam int MAX_CYCLES = 300000;

	logic        sys_clk;
	logic        rst_n;
	logic        scl_i;
	logic        sda_m;               // master drive where 1 releases
	logic        sda_i;
	logic        sda_pull_o;
	int          cycle_cnt;
	int unsigned rng_state;
	string       cur_test;
	logic [7:0]  model [256];
	logic [7:0]  wr_buf [8];

	assign sda_i = sda_m & ~sda_pull_o; // open-drain wired-AND

	i2c_slave_top dut0 (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.sda_pull_o (sda_pull_o)
	);

	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout, the run did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	function automatic logic [6:0] model_addr();
		return model[0][6:0];
	endfunction

	task automatic check_val(input string what, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp) else begin
			$display("ERROR %s, %s: expected %02h, actual %02h", cur_test, what, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	task automatic model_write(input logic [7:0] idx, input logic [7:0] data);
		if (idx == 8'd0) begin
			model[0] = {1'b0, data[6:0]};
		end else if (idx >= `REG_RW_FIRST && idx <= `REG_RW_LAST) begin
			model[idx] = data;
		end
	endtask

	// SCL fall, SDA change mid-low, SCL rise, sample mid-high
	task automatic clock_bit(input logic drive, output logic seen);
		scl_i <= 1'b0;
		wait_cycles(HALF_BIT / 2);
		sda_m <= drive;
		wait_cycles(HALF_BIT / 2);
		scl_i <= 1'b1;
		wait_cycles(HALF_BIT / 2);
		@(negedge sys_clk);
		seen = sda_i;
		wait_cycles(HALF_BIT / 2);
	endtask

	task automatic bus_start(input logic repeated);
		if (repeated) begin
			scl_i <= 1'b0;
			wait_cycles(HALF_BIT / 2);
			sda_m <= 1'b1;
			wait_cycles(HALF_BIT / 2);
			scl_i <= 1'b1;
		end
		wait_cycles(HALF_BIT / 2);
		sda_m <= 1'b0; // SDA falls with SCL high
		wait_cycles(HALF_BIT / 2);
	endtask

	task automatic bus_stop();
		scl_i <= 1'b0;
		wait_cycles(HALF_BIT / 2 - 1);
		@(negedge sys_clk);
		check_val("sda released before stop", 8'h00, {7'd0, sda_pull_o});
		@(posedge sys_clk);
		sda_m <= 1'b0;
		wait_cycles(HALF_BIT / 2);
		scl_i <= 1'b1;
		wait_cycles(HALF_BIT / 2);
		sda_m <= 1'b1;
		wait_cycles(HALF_BIT);
	endtask

	task automatic send_byte(input logic [7:0] data, output logic acked);
		logic seen;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(data[i], seen);
		end
		clock_bit(1'b1, seen);
		acked = !seen;
	endtask

	task automatic recv_byte(input logic nack, output logic [7:0] data);
		logic seen;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, seen);
			data[i] = seen;
		end
		clock_bit(nack, seen);
	endtask

	task automatic write_regs(input logic [6:0] addr, input logic [7:0] ptr, input int n,
			input logic exp_ack);
		logic acked;
		bus_start(1'b0);
		send_byte({addr, 1'b0}, acked);
		check_val("write address ack", {7'd0, exp_ack}, {7'd0, acked});
		send_byte(ptr, acked);
		check_val("pointer ack", {7'd0, exp_ack}, {7'd0, acked});
		for (int k = 0; k < n; k++) begin
			send_byte(wr_buf[k], acked);
			check_val("write data ack", {7'd0, exp_ack}, {7'd0, acked});
			if (exp_ack) begin
				model_write(8'(ptr + k), wr_buf[k]);
			end
		end
		bus_stop();
	endtask

	// pointer write, repeated start, read burst ended by nack
	task automatic read_regs(input logic [6:0] addr, input logic [7:0] ptr, input int n,
			input int idle_bits);
		logic       acked;
		logic       seen;
		logic [7:0] data;
		bus_start(1'b0);
		send_byte({addr, 1'b0}, acked);
		check_val("write address ack", 8'h01, {7'd0, acked});
		send_byte(ptr, acked);
		check_val("pointer ack", 8'h01, {7'd0, acked});
		bus_start(1'b1);
		send_byte({addr, 1'b1}, acked);
		check_val("read address ack", 8'h01, {7'd0, acked});
		for (int k = 0; k < n; k++) begin
			recv_byte(k == n - 1, data);
			check_val("read data", model[8'(ptr + k)], data);
		end
		for (int k = 0; k < idle_bits; k++) begin
			clock_bit(1'b1, seen);
			check_val("sda after nack", 8'h01, {7'd0, seen});
		end
		bus_stop();
	endtask

	initial begin
		logic [7:0] ptr;
		logic [6:0] old_addr;
		int         len;
		sys_clk   = 1'b0;
		rst_n     = 1'b0;
		scl_i     = 1'b1;
		sda_m     = 1'b1;
		cycle_cnt = 0;
		rng_state = 6295;
		for (int i = 0; i < 256; i++) begin
			model[i] = `REG_UNMAPPED_VAL;
		end
		model[0] = {1'b0, `I2C_DEF_DEV_ADDR};
		for (int k = 0; k <= `REG_RO_LAST - `REG_RO_FIRST; k++) begin
			model[`REG_RO_FIRST + k] = 8'(`REG_RO_BASE_VAL + k);
		end
		for (int k = 0; k <= `REG_RW_LAST - `REG_RW_FIRST; k++) begin
			model[`REG_RW_FIRST + k] = 8'(`REG_RW_BASE_VAL + k);
		end
		repeat (4) @(posedge sys_clk);
		rst_n <= 1'b1;

		cur_test = "reset";
		wait_cycles(HALF_BIT);
		@(negedge sys_clk);
		check_val("idle sda pull", 8'h00, {7'd0, sda_pull_o});
		@(posedge sys_clk);
		read_regs(model_addr(), 8'd0, 1, 0);

		cur_test = "random bursts";
		for (int t = 0; t < NUM_RANDOM; t++) begin
			ptr = 8'(next_rand() % 16);
			len = 1 + int'(next_rand() % 6);
			for (int k = 0; k < len; k++) begin
				wr_buf[k] = 8'(next_rand());
			end
			write_regs(model_addr(), ptr, len, 1'b1);
			read_regs(model_addr(), ptr, len, 0);
		end

		cur_test = "read-only and unmapped";
		wr_buf[0] = 8'h11;
		wr_buf[1] = 8'h22;
		wr_buf[2] = 8'h33;
		wr_buf[3] = 8'h44;
		write_regs(model_addr(), `REG_RO_FIRST, 4, 1'b1);
		read_regs(model_addr(), `REG_RO_FIRST, 4, 0);
		write_regs(model_addr(), 8'd200, 2, 1'b1);
		read_regs(model_addr(), 8'd200, 2, 0);
		read_regs(model_addr(), 8'd13, 3, 0);

		cur_test = "address mismatch";
		wr_buf[0] = 8'h5A;
		wr_buf[1] = 8'hA5;
		write_regs(model_addr() ^ 7'h2A, `REG_RW_FIRST, 2, 1'b0);
		read_regs(model_addr(), `REG_RW_FIRST, 8, 0);

		cur_test = "address change";
		old_addr  = model_addr();
		wr_buf[0] = {1'b0, old_addr ^ 7'h5C};
		write_regs(old_addr, 8'd0, 1, 1'b1);
		write_regs(old_addr, 8'd7, 1, 1'b0); // old address now ignored
		wr_buf[0] = 8'hC3;
		write_regs(model_addr(), 8'd7, 1, 1'b1);
		read_regs(model_addr(), 8'd0, 1, 0);
		read_regs(model_addr(), 8'd7, 1, 0);

		cur_test = "master nack";
		read_regs(model_addr(), 8'd9, 3, 8);
		read_regs(model_addr(), `REG_RW_FIRST, 8, 0);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* src/i2c_slave_top.sv */
`timescale 1ns/1ps

module i2c_slave_top
	import i2c_bus_pkg::*;
	import reg_map_pkg::*;
(
	input  logic sys_clk,
	input  logic rst_n,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_pull_o
);

	line_evt_t  line_evt;
	logic       reg_req;
	reg_req_t   reg_req_data;
	logic       reg_ack;
	byte        reg_rdata;
	logic [6:0] dev_addr;

	i2c_line_sampler u_sampler (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.scl_i   (scl_i),
		.sda_i   (sda_i),
		.evt_o   (line_evt)
	);

	i2c_slave_ctrl u_ctrl (
		.sys_clk        (sys_clk),
		.rst_n          (rst_n),
		.evt_i          (line_evt),
		.dev_addr_i     (dev_addr),
		.reg_req_o      (reg_req),
		.reg_req_data_o (reg_req_data),
		.reg_ack_i      (reg_ack),
		.rdata_i        (reg_rdata),
		.sda_pull_o     (sda_pull_o)
	);

	i2c_reg_file u_regs (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.req_i      (reg_req),
		.req_data_i (reg_req_data),
		.ack_o      (reg_ack),
		.rdata_o    (reg_rdata),
		.dev_addr_o (dev_addr)
	);

endmodule

/* src/i2c_reg_file.sv */
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_reg_file
	import reg_map_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       req_i,
	input  reg_req_t   req_data_i,
	output logic       ack_o,
	output byte        rdata_o,
	output logic [6:0] dev_addr_o
);

	localparam int RW_NUM = `REG_RW_LAST - `REG_RW_FIRST + 1;
	localparam int RW_AW  = $clog2(RW_NUM);

	logic [7:0]       rw_mem [RW_NUM];
	logic             access;
	logic             is_dev;
	logic             is_ro;
	logic             is_rw;
	logic [7:0]       ro_off;
	logic [RW_AW-1:0] rw_off;

	assign access = req_i && !ack_o; // first cycle of a request
	assign is_dev = (req_data_i.idx == reg_idx_t'(0));
	assign is_ro  = (req_data_i.idx >= `REG_RO_FIRST) && (req_data_i.idx <= `REG_RO_LAST);
	assign is_rw  = (req_data_i.idx >= `REG_RW_FIRST) && (req_data_i.idx <= `REG_RW_LAST);
	assign ro_off = req_data_i.idx - `REG_RO_FIRST;
	assign rw_off = RW_AW'(req_data_i.idx - `REG_RW_FIRST);

	// ack follows req by one cycle, both edges
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dev_addr_o <= `I2C_DEF_DEV_ADDR;
			for (int k = 0; k < RW_NUM; k++) begin
				rw_mem[k] <= 8'(`REG_RW_BASE_VAL + k);
			end
		end else if (access && req_data_i.write) begin
			if (is_dev) begin
				dev_addr_o <= req_data_i.wdata[6:0];
			end else if (is_rw) begin
				rw_mem[rw_off] <= req_data_i.wdata;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (access) begin
			if (is_dev) begin
				rdata_o <= {1'b0, dev_addr_o};
			end else if (is_ro) begin
				rdata_o <= `REG_RO_BASE_VAL + ro_off; // constants, never stored
			end else if (is_rw) begin
				rdata_o <= rw_mem[rw_off];
			end else begin
				rdata_o <= `REG_UNMAPPED_VAL;
			end
		end
	end

	a_ack_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(ack_o) |-> req_i);

endmodule

/* src/i2c_slave_ctrl.sv */
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_slave_ctrl
	import i2c_bus_pkg::*;
	import reg_map_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  line_evt_t  evt_i,
	input  logic [6:0] dev_addr_i,
	output logic       reg_req_o,
	output reg_req_t   reg_req_data_o,
	input  logic       reg_ack_i,
	input  byte        rdata_i,
	output logic       sda_pull_o
);

	localparam int HOLD_W = $clog2(`I2C_HOLD_CYCLES + 1);

	ctrl_state_t       state;
	logic [3:0]        bit_cnt;     // 0..7 data and 8 for the ack bit
	logic              start_seen;  // next fall only ends the start
	logic [7:0]        rx_sr;
	logic [7:0]        tx_byte;
	reg_idx_t          ptr;
	logic              rd_dir;
	logic [HOLD_W-1:0] hold_cnt;
	logic              next_pull;
	addr_byte_u        rx_byte;
	logic              bit_fall;
	logic              byte_done;
	logic              ack_done;
	logic              xfer_done;
	logic              wr_start;
	logic              rd_start;

	assign rx_byte   = {rx_sr[6:0], evt_i.bit_val};
	assign bit_fall  = evt_i.scl_fall && !start_seen;
	assign byte_done = bit_fall && (bit_cnt == 4'd7);
	assign ack_done  = bit_fall && (bit_cnt == 4'd8);
	assign xfer_done = reg_req_o && reg_ack_i;

	assign wr_start = byte_done && (state == WRITE);
	// read on a matched read address or on a master ack
	assign rd_start = ack_done && ((state == ADDR && rd_dir) ||
		(state == READ && !evt_i.bit_val));

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			bit_cnt    <= '0;
			start_seen <= 1'b0;
			rd_dir     <= 1'b0;
		end else if (evt_i.stop) begin
			state <= IDLE;
		end else if (evt_i.start) begin
			state      <= ADDR;
			bit_cnt    <= '0;
			start_seen <= 1'b1;
		end else if (evt_i.scl_fall && start_seen) begin
			start_seen <= 1'b0;
		end else if (bit_fall) begin
			bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
			case (state)
				ADDR: begin
					if (byte_done) begin
						rd_dir <= rx_byte.fld.rd;
						if (rx_byte.fld.dev_addr != dev_addr_i) begin
							state <= WAIT_STOP; // other target so stay off the bus
						end
					end else if (ack_done) begin
						state <= rd_dir ? READ : PTR;
					end
				end
				PTR: begin
					if (ack_done) begin
						state <= WRITE;
					end
				end
				READ: begin
					if (ack_done && evt_i.bit_val) begin
						state <= WAIT_STOP; // master nack
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		rx_sr <= bit_fall ? rx_byte.raw : rx_sr;
	end

	// register handshake and pointer
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			reg_req_o <= 1'b0;
			ptr       <= '0;
		end else if (xfer_done) begin
			reg_req_o <= 1'b0;
			ptr       <= ptr + 1'b1;
		end else if (wr_start || rd_start) begin
			reg_req_o <= 1'b1;
		end else if (byte_done && state == PTR) begin
			ptr <= rx_byte.raw;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_start || rd_start) begin
			reg_req_data_o.write <= wr_start;
			reg_req_data_o.idx   <= ptr;
			reg_req_data_o.wdata <= rx_byte.raw;
		end
		if (xfer_done && !reg_req_data_o.write) begin
			tx_byte <= rdata_i;
		end
	end

	always_comb begin
		next_pull = 1'b0;
		if (bit_cnt == 4'd8) begin
			next_pull = (state == ADDR) || (state == PTR) || (state == WRITE);
		end else if (state == READ) begin
			next_pull = ~tx_byte[3'd7 - bit_cnt[2:0]]; // msb first
		end
	end

	// drive changes a fixed hold time after each SCL fall
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			hold_cnt   <= '0;
			sda_pull_o <= 1'b0;
		end else if (evt_i.start || evt_i.stop) begin
			hold_cnt   <= '0;
			sda_pull_o <= 1'b0;
		end else if (evt_i.scl_fall) begin
			hold_cnt <= HOLD_W'(`I2C_HOLD_CYCLES - 1);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
			if (hold_cnt == HOLD_W'(1)) begin
				sda_pull_o <= next_pull;
			end
		end
	end

	a_req_after_ack_low: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(reg_req_o) |-> !reg_ack_i);

	a_req_data_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
		reg_req_o && $past(reg_req_o) |-> $stable(reg_req_data_o));

endmodule

/* src/i2c_line_sampler.sv */
`timescale 1ns/1ps
`include "i2c_macros.svh"

module i2c_line_sampler
	import i2c_bus_pkg::*;
(
	input  logic      sys_clk,
	input  logic      rst_n,
	input  logic      scl_i,
	input  logic      sda_i,
	output line_evt_t evt_o
);

	localparam int VOTE_W = $clog2(`I2C_SDA_VOTE_MIN + 1);

	logic [1:0]        scl_sync;
	logic [1:0]        sda_sync;
	logic              scl_prev;
	logic              sda_prev;
	logic [VOTE_W-1:0] vote_cnt;
	logic              scl_rise;
	logic              scl_fall;
	logic              sda_rise;
	logic              sda_fall;

	assign scl_rise = scl_sync[1] & ~scl_prev;
	assign scl_fall = ~scl_sync[1] & scl_prev;
	assign sda_rise = sda_sync[1] & ~sda_prev;
	assign sda_fall = ~sda_sync[1] & sda_prev;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scl_sync <= 2'b11; // bus idles high
			sda_sync <= 2'b11;
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[0], scl_i};
			sda_sync <= {sda_sync[0], sda_i};
			scl_prev <= scl_sync[1];
			sda_prev <= sda_sync[1];
		end
	end

	// count high SDA samples over the SCL high phase
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			vote_cnt <= '0;
		end else if (scl_rise) begin
			vote_cnt <= '0;
		end else if (scl_sync[1] && sda_sync[1] &&
				vote_cnt != VOTE_W'(`I2C_SDA_VOTE_MIN)) begin
			vote_cnt <= vote_cnt + 1'b1; // saturates at threshold
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			evt_o <= '0;
		end else begin
			evt_o.start    <= sda_fall & scl_sync[1] & scl_prev;
			evt_o.stop     <= sda_rise & scl_sync[1] & scl_prev;
			evt_o.scl_fall <= scl_fall;
			evt_o.scl_rise <= scl_rise;
			evt_o.bit_val  <= (vote_cnt >= VOTE_W'(`I2C_SDA_VOTE_MIN));
		end
	end

	a_no_start_and_stop: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(evt_o.start && evt_o.stop));

endmodule

/* src/reg_map_pkg.sv */
package reg_map_pkg;

	typedef logic [7:0] reg_idx_t; // register pointer

	// one register access, held stable while req is high
	typedef struct packed {
		logic       write;
		reg_idx_t   idx;
		logic [7:0] wdata;
	} reg_req_t;

endpackage

/* src/i2c_bus_pkg.sv */
package i2c_bus_pkg;

	// one bus observation, every field but bit_val is a single-cycle pulse
	typedef struct packed {
		logic start;
		logic stop;
		logic scl_fall;
		logic scl_rise;
		logic bit_val; // valid with scl_fall
	} line_evt_t;

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		PTR,
		WRITE,
		READ,
		WAIT_STOP
	} ctrl_state_t;

	typedef struct packed {
		logic [6:0] dev_addr;
		logic       rd; // 1 = master reads
	} addr_fields_t;

	// first byte after start, seen raw or split
	typedef union packed {
		logic [7:0]   raw;
		addr_fields_t fld;
	} addr_byte_u;

endpackage

/* src/i2c_macros.svh */
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// 7-bit device address after reset, register 0 can change it
`define I2C_DEF_DEV_ADDR 7'h36

// high SDA samples while SCL high needed to read a 1
`define I2C_SDA_VOTE_MIN 16
// sys_clk cycles from SCL fall to SDA drive change
`define I2C_HOLD_CYCLES 8

// register map bounds
`define REG_RO_FIRST 8'd1
`define REG_RO_LAST 8'd4
`define REG_RW_FIRST 8'd5
`define REG_RW_LAST 8'd12

`define REG_RO_BASE_VAL 8'hA0 // reg 1+k reads base+k
`define REG_RW_BASE_VAL 8'hB0 // reg 5+k resets to base+k
`define REG_UNMAPPED_VAL 8'hFF

`endif
